// File: Bender.yml
package:
  name: dec_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/dec_pkg.sv
      - logic/instr_decoder.sv
      - logic/imm_gen.sv
      - logic/gpr_file.sv
      - logic/operand_select.sv
      - logic/load_hazard_fsm.sv
      - logic/fence_timer.sv
      - logic/dec_ex_reg.sv
      - logic/dec_stage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_dec_stage.sv

// File: build.f
+incdir+logic
logic/dec_pkg.sv
logic/instr_decoder.sv
logic/imm_gen.sv
logic/gpr_file.sv
logic/operand_select.sv
logic/load_hazard_fsm.sv
logic/fence_timer.sv
logic/dec_ex_reg.sv
logic/dec_stage.sv
tests/tb_clock_gen.sv
tests/tb_dec_stage.sv

// File: logic/dec_config.svh
`ifndef DEC_CONFIG_SVH
`define DEC_CONFIG_SVH

// datapath widths
`define XLEN            32
`define INSTR_WIDTH     32
`define REG_IDX_WIDTH   6     // one spare bit above the 5-bit index

// index that never matches a real register
`define NO_REG          6'd32

// major opcodes
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_ALU_IR      7'b0010011
`define OPC_ALU_RR      7'b0110011
`define OPC_FENCE       7'b0001111

// funct7 values
`define F7_BASE         7'b0000000
`define F7_ALT          7'b0100000   // sub and sra

// fence stall window
`define FENCE_STALL_CYCLES  5
`define FENCE_CNT_WIDTH     3

`endif

// File: logic/dec_ex_reg.sv
`timescale 1ns/100ps

module dec_ex_reg #(
	parameter type payload_t = logic,
	parameter bit CLEAR_ON_KILL = 1'b1
) (
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic ex_ready,
	input logic bubble,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	logic kill;

	assign kill = flush || (ex_ready && bubble);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			q <= '0;
		else if (kill)
		begin
			if (CLEAR_ON_KILL)
				q <= '0;   // otherwise keep old contents
		end
		else if (ex_ready)
			q <= d;
	end

endmodule

// File: logic/dec_pkg.sv
`include "dec_config.svh"

package dec_pkg;

	typedef logic [`XLEN-1:0] xlen_t;
	typedef logic [`INSTR_WIDTH-1:0] instr_t;
	typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

	// one-hot ALU select
	typedef struct packed {
		logic op_add;
		logic op_sub;
		logic op_com;   // signed compare
		logic op_ucom;  // unsigned compare
		logic op_and;
		logic op_or;
		logic op_xor;
		logic op_sll;
		logic op_srl;
		logic op_sra;
	} alu_op_t;

	// one-hot branch type
	typedef struct packed {
		logic beq;
		logic bne;
		logic blt;
		logic bge;
		logic bltu;
		logic bgeu;
	} br_op_t;

	typedef struct packed {
		logic valid;    // set for an accepted instruction, cleared by bubble or flush
		alu_op_t alu_op;
		br_op_t br_op;
		logic load;
		logic store;
		logic mem_h;
		logic mem_b;
		logic mem_u;
		logic jalr;
		logic only_src2_used;
		reg_idx_t rd;
	} ctrl_pl_t;

	typedef struct packed {
		xlen_t src1;
		xlen_t src2;
		xlen_t store_data;
		xlen_t imm;
		xlen_t pc;
	} data_pl_t;

endpackage

// File: logic/dec_stage.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module dec_stage (
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic if_valid,
	input dec_pkg::instr_t instr_dec,
	input dec_pkg::xlen_t pc_dec,
	input logic ex_ready,
	input logic branch_taken_ex,
	input logic exception_met,
	input dec_pkg::xlen_t alu_result_ex,
	input dec_pkg::reg_idx_t rd_mem,
	input dec_pkg::xlen_t data_mem,
	input logic mem_wb_data_valid,
	input logic wr_valid_wb,
	input dec_pkg::reg_idx_t rd_wb,
	input dec_pkg::xlen_t wr_data_wb,
	output logic dec_ready,
	output logic dec_valid,
	output logic jal_dec,
	output dec_pkg::xlen_t imm_dec,
	output logic fence_dec,
	output dec_pkg::xlen_t src_data1_ex,
	output dec_pkg::xlen_t src_data2_ex,
	output dec_pkg::xlen_t store_data_ex,
	output dec_pkg::xlen_t imm_ex,
	output dec_pkg::xlen_t pc_ex,
	output dec_pkg::alu_op_t alu_op_ex,
	output dec_pkg::br_op_t br_op_ex,
	output logic load_ex,
	output logic store_ex,
	output logic mem_h_ex,
	output logic mem_b_ex,
	output logic mem_u_ex,
	output logic jalr_ex,
	output logic only_src2_used_ex,
	output dec_pkg::reg_idx_t rd_ex
);

	dec_pkg::alu_op_t alu_op;
	dec_pkg::br_op_t br_op;
	logic is_load, is_store, is_jal, is_jalr, is_auipc, is_fence;
	logic use_rs2, use_imm, src1_unused, only_src2_used;
	logic mem_h, mem_b, mem_u;
	dec_pkg::reg_idx_t rd_dec, rs1, rs2;
	dec_pkg::xlen_t rdata1, rdata2, src1, src2, store_data;
	logic hazard_stall, fence_stall, fence_req, dec_stall;
	logic bubble, flush;
	dec_pkg::ctrl_pl_t ctrl_d, ctrl_q;
	dec_pkg::data_pl_t data_d, data_q;

	assign dec_stall = hazard_stall || fence_stall;
	assign dec_ready = !dec_stall && ex_ready;
	assign bubble = !if_valid || dec_stall;
	assign flush = branch_taken_ex || exception_met || jalr_ex;
	assign jal_dec = is_jal && !dec_stall;
	assign fence_req = is_fence && ex_ready && !hazard_stall;   // fence about to be accepted

	instr_decoder i_decoder (
		.instr(instr_dec), .valid(if_valid), .alu_op(alu_op), .br_op(br_op),
		.is_load(is_load), .is_store(is_store), .is_jal(is_jal), .is_jalr(is_jalr),
		.is_auipc(is_auipc), .is_fence(is_fence), .use_rs2(use_rs2), .use_imm(use_imm),
		.src1_unused(src1_unused), .only_src2_used(only_src2_used),
		.mem_h(mem_h), .mem_b(mem_b), .mem_u(mem_u), .rd(rd_dec), .rs1(rs1), .rs2(rs2)
	);

	imm_gen i_imm_gen (.instr(instr_dec), .imm(imm_dec));

	gpr_file i_gpr_file (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .wr_valid(wr_valid_wb), .rd_wb(rd_wb),
		.wr_data(wr_data_wb), .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2)
	);

	operand_select i_operand_select (
		.rs1(rs1), .rs2(rs2), .rd_ex(rd_ex), .rd_mem(rd_mem), .rd_wb(rd_wb),
		.prev_load(load_ex), .alu_result_ex(alu_result_ex), .data_mem(data_mem),
		.wr_data_wb(wr_data_wb), .rdata1(rdata1), .rdata2(rdata2), .imm(imm_dec),
		.pc(pc_dec), .is_auipc(is_auipc), .is_jal(is_jal), .is_jalr(is_jalr),
		.src1_unused(src1_unused), .use_rs2(use_rs2), .use_imm(use_imm),
		.src1(src1), .src2(src2), .store_data(store_data)
	);

	load_hazard_fsm i_load_hazard (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .rs1(rs1), .rs2(rs2), .rd_ex(rd_ex),
		.src1_unused(src1_unused), .load_ex(load_ex),
		.mem_wb_data_valid(mem_wb_data_valid), .rd_mem(rd_mem), .stall(hazard_stall)
	);

	fence_timer i_fence_timer (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .is_fence(fence_req),
		.fence_pulse(fence_dec), .stall(fence_stall)
	);

	assign ctrl_d = '{valid: 1'b1, alu_op: alu_op, br_op: br_op, load: is_load,
		store: is_store, mem_h: mem_h, mem_b: mem_b, mem_u: mem_u, jalr: is_jalr,
		only_src2_used: only_src2_used, rd: rd_dec};
	assign data_d = '{src1: src1, src2: src2, store_data: store_data, imm: imm_dec, pc: pc_dec};

	// control clears on bubble and flush
	dec_ex_reg #(.payload_t(dec_pkg::ctrl_pl_t), .CLEAR_ON_KILL(1'b1)) i_ctrl_reg (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .ex_ready(ex_ready), .bubble(bubble),
		.flush(flush), .d(ctrl_d), .q(ctrl_q)
	);

	// data only moves with an accepted instruction
	dec_ex_reg #(.payload_t(dec_pkg::data_pl_t), .CLEAR_ON_KILL(1'b0)) i_data_reg (
		.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn), .ex_ready(ex_ready), .bubble(bubble),
		.flush(flush), .d(data_d), .q(data_q)
	);

	assign dec_valid = ctrl_q.valid;
	assign alu_op_ex = ctrl_q.alu_op;
	assign br_op_ex = ctrl_q.br_op;
	assign load_ex = ctrl_q.load;
	assign store_ex = ctrl_q.store;
	assign mem_h_ex = ctrl_q.mem_h;
	assign mem_b_ex = ctrl_q.mem_b;
	assign mem_u_ex = ctrl_q.mem_u;
	assign jalr_ex = ctrl_q.jalr;
	assign only_src2_used_ex = ctrl_q.only_src2_used;
	assign rd_ex = ctrl_q.valid ? ctrl_q.rd : `NO_REG;   // empty slot writes nothing

	assign src_data1_ex = data_q.src1;
	assign src_data2_ex = data_q.src2;
	assign store_data_ex = data_q.store_data;
	assign imm_ex = data_q.imm;
	assign pc_ex = data_q.pc;

endmodule

// File: logic/fence_timer.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module fence_timer (
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic is_fence,
	output logic fence_pulse,
	output logic stall
);

	logic [`FENCE_CNT_WIDTH-1:0] cnt;   // cycles left in the window

	assign fence_pulse = is_fence && (cnt == '0);
	assign stall = (cnt != '0);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
			cnt <= '0;
		else if (fence_pulse)
			cnt <= `FENCE_CNT_WIDTH'(`FENCE_STALL_CYCLES);
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
	end

endmodule

// File: logic/gpr_file.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module gpr_file (
	input logic cpu_clk,
	input logic cpu_rstn,
	input logic wr_valid,
	input dec_pkg::reg_idx_t rd_wb,
	input dec_pkg::xlen_t wr_data,
	input dec_pkg::reg_idx_t rs1,
	input dec_pkg::reg_idx_t rs2,
	output dec_pkg::xlen_t rdata1,
	output dec_pkg::xlen_t rdata2
);

	dec_pkg::xlen_t regs [1:31];   // x0 is not stored
	logic wr_en;

	assign wr_en = wr_valid && (rd_wb < `NO_REG) && (rd_wb != '0);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[rd_wb[4:0]] <= wr_data;
	end

	assign rdata1 = (rs1 == '0 || rs1 >= `NO_REG) ? '0 : regs[rs1[4:0]];
	assign rdata2 = (rs2 == '0 || rs2 >= `NO_REG) ? '0 : regs[rs2[4:0]];

	// writeback must never target x0
	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn) wr_valid |-> rd_wb != '0)
		else $error("gpr_file: write attempted to x0");

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module imm_gen (
	input dec_pkg::instr_t instr,
	output dec_pkg::xlen_t imm
);

	always_comb
	begin
		case (instr[6:0])
			`OPC_LOAD, `OPC_ALU_IR, `OPC_JALR:
				imm = {{20{instr[31]}}, instr[31:20]};
			`OPC_STORE:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			`OPC_BRANCH:   // offset in halfwords
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			`OPC_JAL:
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			`OPC_LUI, `OPC_AUIPC:
				imm = {instr[31:12], 12'h000};
			default:       // R-type, fence
				imm = '0;
		endcase
	end

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module instr_decoder (
	input dec_pkg::instr_t instr,
	input logic valid,
	output dec_pkg::alu_op_t alu_op,
	output dec_pkg::br_op_t br_op,
	output logic is_load,
	output logic is_store,
	output logic is_jal,
	output logic is_jalr,
	output logic is_auipc,
	output logic is_fence,
	output logic use_rs2,
	output logic use_imm,
	output logic src1_unused,
	output logic only_src2_used,
	output logic mem_h,
	output logic mem_b,
	output logic mem_u,
	output dec_pkg::reg_idx_t rd,
	output dec_pkg::reg_idx_t rs1,
	output dec_pkg::reg_idx_t rs2
);

	dec_pkg::instr_t vinstr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic op_lui;
	logic op_branch;
	logic op_alu_ir;
	logic op_alu_rr;
	logic alu_std;      // ops picked by funct3 alone
	logic i_type;
	logic writes_rd;

	assign vinstr = valid ? instr : '0;
	assign opcode = vinstr[6:0];
	assign funct3 = vinstr[14:12];
	assign funct7 = vinstr[31:25];

	assign op_lui    = (opcode == `OPC_LUI);
	assign is_auipc  = (opcode == `OPC_AUIPC);
	assign is_jal    = (opcode == `OPC_JAL);
	assign is_jalr   = (opcode == `OPC_JALR);
	assign op_branch = (opcode == `OPC_BRANCH);
	assign is_load   = (opcode == `OPC_LOAD);
	assign is_store  = (opcode == `OPC_STORE);
	assign op_alu_ir = (opcode == `OPC_ALU_IR);
	assign op_alu_rr = (opcode == `OPC_ALU_RR);
	assign is_fence  = (opcode == `OPC_FENCE) && (funct3[2:1] == 2'b00); // fence, fence.i

	assign alu_std = op_alu_ir || (op_alu_rr && funct7 == `F7_BASE);

	always_comb
	begin
		alu_op.op_add  = is_auipc || is_load || is_store || (alu_std && funct3 == 3'b000);
		alu_op.op_sub  = (op_alu_rr && funct7 == `F7_ALT && funct3 == 3'b000) ||
			(op_branch && funct3[2:1] == 2'b00);
		alu_op.op_com  = (op_branch && funct3[2:1] == 2'b10) || (alu_std && funct3 == 3'b010);
		alu_op.op_ucom = (op_branch && funct3[2:1] == 2'b11) || (alu_std && funct3 == 3'b011);
		alu_op.op_and  = alu_std && funct3 == 3'b111;
		alu_op.op_or   = alu_std && funct3 == 3'b110;
		alu_op.op_xor  = alu_std && funct3 == 3'b100;
		alu_op.op_sll  = alu_std && funct3 == 3'b001;
		// shift right needs funct7 for both formats
		alu_op.op_srl  = (op_alu_ir || op_alu_rr) && funct3 == 3'b101 && funct7 == `F7_BASE;
		alu_op.op_sra  = (op_alu_ir || op_alu_rr) && funct3 == 3'b101 && funct7 == `F7_ALT;
	end

	always_comb
	begin
		br_op.beq  = op_branch && funct3 == 3'b000;
		br_op.bne  = op_branch && funct3 == 3'b001;
		br_op.blt  = op_branch && funct3 == 3'b100;
		br_op.bge  = op_branch && funct3 == 3'b101;
		br_op.bltu = op_branch && funct3 == 3'b110;
		br_op.bgeu = op_branch && funct3 == 3'b111;
	end

	// access size from funct3
	assign mem_h = (is_load || is_store) && (funct3 == 3'b001 || funct3 == 3'b101);
	assign mem_b = (is_load || is_store) && (funct3 == 3'b000 || funct3 == 3'b100);
	assign mem_u = (is_load || is_store) && (funct3 == 3'b100 || funct3 == 3'b101);

	assign i_type = is_load || op_alu_ir || is_jalr;
	assign use_rs2 = op_alu_rr || op_branch;
	assign use_imm = i_type || is_store || op_lui || is_auipc;
	assign src1_unused = op_lui || is_jal;
	assign only_src2_used = op_lui || is_jal || is_jalr;

	assign writes_rd = op_alu_rr || i_type || op_lui || is_auipc || is_jal;
	assign rd  = writes_rd ? {1'b0, vinstr[11:7]} : `NO_REG;
	assign rs1 = {1'b0, vinstr[19:15]};
	assign rs2 = {1'b0, vinstr[24:20]};

endmodule

// File: logic/load_hazard_fsm.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module load_hazard_fsm (
	input logic cpu_clk,
	input logic cpu_rstn,
	input dec_pkg::reg_idx_t rs1,
	input dec_pkg::reg_idx_t rs2,
	input dec_pkg::reg_idx_t rd_ex,
	input logic src1_unused,
	input logic load_ex,
	input logic mem_wb_data_valid,
	input dec_pkg::reg_idx_t rd_mem,
	output logic stall
);

	typedef enum logic {IDLE, WAIT_LOAD} state_t;

	state_t state;
	dec_pkg::reg_idx_t pend_idx;   // register the load will write
	logic rs1_hit;
	logic rs2_hit;
	logic hit;
	logic clr;

	assign rs1_hit = load_ex && !src1_unused && (rs1 == rd_ex);
	assign rs2_hit = load_ex && (rs2 == rd_ex);
	assign hit = (state == IDLE) && (rs1_hit || rs2_hit);

	// load data shows up on the MEM forwarding path
	assign clr = (state == WAIT_LOAD) && mem_wb_data_valid && (rd_mem == pend_idx);

	assign stall = hit || ((state == WAIT_LOAD) && !clr);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			state <= IDLE;
			pend_idx <= `NO_REG;
		end
		else if (hit)
		begin
			state <= WAIT_LOAD;
			pend_idx <= rs1_hit ? rs1 : rs2;
		end
		else if (clr)
		begin
			state <= IDLE;
			pend_idx <= `NO_REG;
		end
	end

	assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		state == WAIT_LOAD |-> pend_idx != `NO_REG)
		else $error("load_hazard_fsm: waiting without a pending register");

endmodule

// File: logic/operand_select.sv
`timescale 1ns/100ps

module operand_select (
	input dec_pkg::reg_idx_t rs1,
	input dec_pkg::reg_idx_t rs2,
	input dec_pkg::reg_idx_t rd_ex,
	input dec_pkg::reg_idx_t rd_mem,
	input dec_pkg::reg_idx_t rd_wb,
	input logic prev_load,
	input dec_pkg::xlen_t alu_result_ex,
	input dec_pkg::xlen_t data_mem,
	input dec_pkg::xlen_t wr_data_wb,
	input dec_pkg::xlen_t rdata1,
	input dec_pkg::xlen_t rdata2,
	input dec_pkg::xlen_t imm,
	input dec_pkg::xlen_t pc,
	input logic is_auipc,
	input logic is_jal,
	input logic is_jalr,
	input logic src1_unused,
	input logic use_rs2,
	input logic use_imm,
	output dec_pkg::xlen_t src1,
	output dec_pkg::xlen_t src2,
	output dec_pkg::xlen_t store_data
);

	dec_pkg::xlen_t fwd1;
	dec_pkg::xlen_t fwd2;

	// youngest producer wins
	function automatic dec_pkg::xlen_t fwd(
		input dec_pkg::reg_idx_t rs,
		input dec_pkg::xlen_t rf_data
	);
		if (rs == '0)
			return '0;
		else if (!prev_load && rs == rd_ex)   // load result not ready in EX
			return alu_result_ex;
		else if (rs == rd_mem)
			return data_mem;
		else if (rs == rd_wb)
			return wr_data_wb;
		else
			return rf_data;
	endfunction

	always_comb
	begin
		fwd1 = fwd(rs1, rdata1);
		fwd2 = fwd(rs2, rdata2);
	end

	always_comb
	begin
		if (is_auipc)
			src1 = pc;
		else if (src1_unused)
			src1 = '0;
		else
			src1 = fwd1;
	end

	always_comb
	begin
		if (is_jal || is_jalr)
			src2 = pc + 32'd4;   // link address
		else if (use_rs2)
			src2 = fwd2;
		else if (use_imm)
			src2 = imm;
		else
			src2 = '0;
	end

	assign store_data = fwd2;

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic cpu_clk,
	output logic cpu_rstn
);

	initial
	begin
		cpu_clk = 1'b0;
		forever
			#5 cpu_clk = ~cpu_clk;   // 10 ns period
	end

	initial
	begin
		cpu_rstn = 1'b0;
		repeat (10) @(posedge cpu_clk);
		@(negedge cpu_clk);
		cpu_rstn = 1'b1;
	end

endmodule

// File: tests/tb_dec_stage.sv
`timescale 1ns/100ps
`include "dec_config.svh"

module tb_dec_stage;

	typedef struct packed {
		logic [9:0] alu;     // add sub com ucom and or xor sll srl sra
		logic [5:0] br;      // beq bne blt bge bltu bgeu
		logic load, store, mem_h, mem_b, mem_u, jalr, only2;
		dec_pkg::reg_idx_t rd;
		dec_pkg::xlen_t src1, src2, sdata, imm, pc;
		logic stall, jal, fence, hit;
		dec_pkg::reg_idx_t hit_idx;
	} exp_t;

	logic cpu_clk, cpu_rstn;
	logic if_valid, ex_ready, branch_taken_ex, exception_met;
	logic mem_wb_data_valid, wr_valid_wb;
	dec_pkg::instr_t instr_dec;
	dec_pkg::xlen_t pc_dec, alu_result_ex, data_mem, wr_data_wb;
	dec_pkg::reg_idx_t rd_mem, rd_wb;
	logic dec_ready, dec_valid, jal_dec, fence_dec;
	dec_pkg::xlen_t imm_dec, src_data1_ex, src_data2_ex, store_data_ex, imm_ex, pc_ex;
	dec_pkg::alu_op_t alu_op_ex;
	dec_pkg::br_op_t br_op_ex;
	logic load_ex, store_ex, mem_h_ex, mem_b_ex, mem_u_ex, jalr_ex, only_src2_used_ex;
	dec_pkg::reg_idx_t rd_ex;

	// model state of the stage
	dec_pkg::xlen_t gpr [0:31];
	dec_pkg::reg_idx_t prev_rd;
	logic prev_load;
	logic pend;
	dec_pkg::reg_idx_t pend_idx;
	int fcnt;
	logic [31:0] seed;
	exp_t exp_q[$];
	exp_t last_exp;

	tb_clock_gen i_clk (.cpu_clk(cpu_clk), .cpu_rstn(cpu_rstn));

	dec_stage i_dut (.*);

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [4:0] rand_idx(input int max);
		return 5'((next_rand() >> 16) % max);
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] expv);
		if (got !== expv)
		begin
			$display("** Error: %s got %h expected %h", name, got, expv);
			stop_run("value mismatch");
		end
	endtask

	function automatic dec_pkg::xlen_t fwd_value(input dec_pkg::reg_idx_t rs);
		if (rs == 0)
			return '0;
		if (!prev_load && rs == prev_rd)
			return alu_result_ex;
		if (rs == rd_mem)
			return data_mem;
		if (rs == rd_wb)
			return wr_data_wb;
		return gpr[rs[4:0]];
	endfunction

	// expected stage behavior from the RV32I rules
	function automatic exp_t ref_decode(input logic [31:0] ins, input logic [31:0] pc);
		exp_t e;
		logic [6:0] opc;
		logic [2:0] f3;
		logic alt, rr, ir, lui, auipc, jal, jalr, br, ld, st, fen, h1, h2, clr, hz;
		dec_pkg::reg_idx_t rs1, rs2;
		e = '0;
		opc = ins[6:0];
		f3 = ins[14:12];
		alt = (ins[31:25] == `F7_ALT);
		rr = (opc == `OPC_ALU_RR);
		ir = (opc == `OPC_ALU_IR);
		lui = (opc == `OPC_LUI);
		auipc = (opc == `OPC_AUIPC);
		jal = (opc == `OPC_JAL);
		jalr = (opc == `OPC_JALR);
		br = (opc == `OPC_BRANCH);
		ld = (opc == `OPC_LOAD);
		st = (opc == `OPC_STORE);
		fen = (opc == `OPC_FENCE) && (f3[2:1] == 2'b00);
		rs1 = {1'b0, ins[19:15]};
		rs2 = {1'b0, ins[24:20]};
		e.pc = pc;
		if (ld || ir || jalr)
			e.imm = {{20{ins[31]}}, ins[31:20]};
		else if (st)
			e.imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		else if (br)
			e.imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		else if (jal)
			e.imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		else if (lui || auipc)
			e.imm = {ins[31:12], 12'h000};
		if (rr || ir)
		begin
			case (f3)
				3'b000: e.alu = (rr && alt) ? 10'b0100000000 : 10'b1000000000;
				3'b001: e.alu[2] = 1'b1;
				3'b010: e.alu[7] = 1'b1;
				3'b011: e.alu[6] = 1'b1;
				3'b100: e.alu[3] = 1'b1;
				3'b101: e.alu = alt ? 10'b0000000001 : 10'b0000000010;
				3'b110: e.alu[4] = 1'b1;
				default: e.alu[5] = 1'b1;
			endcase
		end
		if (auipc || ld || st)
			e.alu[9] = 1'b1;
		if (br)
		begin
			e.alu[8] = (f3[2:1] == 2'b00);
			e.alu[7] = (f3[2:1] == 2'b10);
			e.alu[6] = (f3[2:1] == 2'b11);
			e.br = 6'b100000 >> (f3[2] ? f3 - 3'd2 : f3);
		end
		e.load = ld;
		e.store = st;
		e.mem_b = (ld || st) && (f3 == 3'b000 || f3 == 3'b100);
		e.mem_h = (ld || st) && (f3 == 3'b001 || f3 == 3'b101);
		e.mem_u = (ld || st) && (f3 == 3'b100 || f3 == 3'b101);
		e.jalr = jalr;
		e.only2 = lui || jal || jalr;
		e.rd = (rr || ir || ld || jalr || lui || auipc || jal) ? {1'b0, ins[11:7]} : `NO_REG;
		e.src1 = auipc ? pc : ((lui || jal) ? '0 : fwd_value(rs1));
		if (jal || jalr)
			e.src2 = pc + 32'd4;
		else if (rr || br)
			e.src2 = fwd_value(rs2);
		else if (ir || ld || st || lui || auipc)
			e.src2 = e.imm;
		e.sdata = fwd_value(rs2);
		// load-use check is conservative on rs2
		h1 = prev_load && !(lui || jal) && rs1 == prev_rd;
		h2 = prev_load && rs2 == prev_rd;
		e.hit = !pend && (h1 || h2);
		e.hit_idx = h1 ? rs1 : rs2;
		clr = pend && mem_wb_data_valid && rd_mem == pend_idx;
		hz = e.hit || (pend && !clr);
		e.stall = hz || fcnt != 0;
		e.jal = jal && !e.stall;
		e.fence = fen && !hz && fcnt == 0;
		return e;
	endfunction

	// advance the model by one edge with ex_ready high
	task automatic model_step(output logic acc);
		exp_t e;
		e = ref_decode(if_valid ? instr_dec : '0, pc_dec);
		acc = if_valid && !e.stall;
		if (pend)
		begin
			if (mem_wb_data_valid && rd_mem == pend_idx)
				pend = 1'b0;
		end
		else if (e.hit)
		begin
			pend = 1'b1;
			pend_idx = e.hit_idx;
		end
		if (e.fence)
			fcnt = `FENCE_STALL_CYCLES;
		else if (fcnt != 0)
			fcnt--;
		prev_rd = acc ? e.rd : `NO_REG;
		prev_load = acc && e.load;
	endtask

	task automatic check_outputs(input exp_t e);
		compare_value("dec_valid", dec_valid, 1'b1);
		compare_value("alu_op_ex", alu_op_ex, e.alu);
		compare_value("br_op_ex", br_op_ex, e.br);
		compare_value("load_ex", load_ex, e.load);
		compare_value("store_ex", store_ex, e.store);
		compare_value("mem_h_ex", mem_h_ex, e.mem_h);
		compare_value("mem_b_ex", mem_b_ex, e.mem_b);
		compare_value("mem_u_ex", mem_u_ex, e.mem_u);
		compare_value("jalr_ex", jalr_ex, e.jalr);
		compare_value("only_src2_used_ex", only_src2_used_ex, e.only2);
		compare_value("rd_ex", rd_ex, e.rd);
		compare_value("src_data1_ex", src_data1_ex, e.src1);
		compare_value("src_data2_ex", src_data2_ex, e.src2);
		compare_value("store_data_ex", store_data_ex, e.sdata);
		compare_value("imm_ex", imm_ex, e.imm);
		compare_value("pc_ex", pc_ex, e.pc);
	endtask

	// EX outputs after each accepting edge
	always @(negedge cpu_clk)
	begin
		if (exp_q.size() != 0)
			check_outputs(exp_q.pop_front());
	end

	task automatic present(input logic [31:0] ins);
		if_valid <= 1'b1;
		instr_dec <= ins;
		pc_dec <= next_rand() & 32'hffff_fffc;
	endtask

	task automatic wait_accept();
		exp_t e;
		logic acc;
		int n;
		acc = 1'b0;
		for (n = 0; n < 40 && !acc; n++)
		begin
			@(negedge cpu_clk);
			e = ref_decode(instr_dec, pc_dec);
			compare_value("dec_ready", dec_ready, !e.stall);
			if (!e.stall)
			begin
				compare_value("jal_dec", jal_dec, e.jal);
				compare_value("imm_dec", imm_dec, e.imm);
				compare_value("fence_dec", fence_dec, e.fence);
			end
			@(posedge cpu_clk);
			model_step(acc);
			if (acc)
			begin
				exp_q.push_back(e);
				last_exp = e;
			end
		end
		if (!acc)
			stop_run("timeout while waiting for the instruction to be accepted");
	endtask

	task automatic issue(input logic [31:0] ins);
		present(ins);
		wait_accept();
	endtask

	task automatic idle();
		logic acc;
		if_valid <= 1'b0;
		@(posedge cpu_clk);
		model_step(acc);
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
		logic acc;
		wr_valid_wb <= 1'b1;
		rd_wb <= {1'b0, idx};
		wr_data_wb <= val;
		@(posedge cpu_clk);
		model_step(acc);
		gpr[idx] = val;
	endtask

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OPC_ALU_RR};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		logic [31:0] r;
		logic [2:0] f3;
		logic [6:0] f7;
		r = next_rand();
		f3 = r[18:16];
		f7 = (r[20] && (f3 == 3'b000 || f3 == 3'b101)) ? `F7_ALT : `F7_BASE;
		if (r[22])
			return enc_r(f7, rs2, rs1, f3, rd);
		if (f3 == 3'b001 || f3 == 3'b101)   // shift amount in the low bits
			return enc_i({(f3 == 3'b101) ? f7 : `F7_BASE, r[28:24]}, rs1, f3, rd, `OPC_ALU_IR);
		return enc_i(r[31:20], rs1, f3, rd, `OPC_ALU_IR);
	endfunction

	initial
	begin
		int i;
		int n;
		logic [31:0] r;
		logic [4:0] ld_rd;
		seed = 32'hc798;
		for (i = 0; i < 32; i++)
			gpr[i] = '0;
		prev_rd = `NO_REG;
		prev_load = 1'b0;
		pend = 1'b0;
		pend_idx = `NO_REG;
		fcnt = 0;
		if_valid <= 1'b0;
		instr_dec <= '0;
		pc_dec <= '0;
		ex_ready <= 1'b1;
		branch_taken_ex <= 1'b0;
		exception_met <= 1'b0;
		alu_result_ex <= '0;
		rd_mem <= `NO_REG;
		data_mem <= '0;
		mem_wb_data_valid <= 1'b0;
		wr_valid_wb <= 1'b0;
		rd_wb <= `NO_REG;
		wr_data_wb <= '0;
		n = 0;
		while (cpu_rstn !== 1'b1 && n < 100)
		begin
			@(posedge cpu_clk);
			n++;
		end
		if (cpu_rstn !== 1'b1)
			stop_run("reset was never released");
		@(posedge cpu_clk);

		// random ALU ops on a written register file
		for (i = 1; i < 32; i++)
			write_reg(5'(i), next_rand());
		wr_valid_wb <= 1'b0;
		rd_wb <= `NO_REG;
		for (i = 0; i < 40; i++)
		begin
			issue(rand_alu(rand_idx(31) + 5'd1, rand_idx(32), rand_idx(32)));
			idle();
		end

		// colliding forwarding sources, back to back
		for (i = 0; i < 30; i++)
		begin
			alu_result_ex <= next_rand();
			data_mem <= next_rand();
			wr_data_wb <= next_rand();
			rd_mem <= {1'b0, rand_idx(6)};
			rd_wb <= {1'b0, rand_idx(6)};
			issue(rand_alu(rand_idx(4) + 5'd1, rand_idx(5), rand_idx(5)));
		end
		rd_mem <= `NO_REG;
		rd_wb <= `NO_REG;
		idle();

		// upper immediates, jumps and branches
		for (i = 0; i < 6; i++)
		begin
			r = next_rand();
			issue({r[31:12], r[11:7], `OPC_LUI});
			idle();
			issue({r[19:0], rand_idx(32), `OPC_AUIPC});
			idle();
			r = next_rand();
			issue({r[31:12], rand_idx(32), `OPC_JAL});
			idle();
			issue(enc_i(r[31:20], rand_idx(32), 3'b000, rand_idx(32), `OPC_JALR));
			idle();   // jalr flushes this slot
			issue({r[30:24], rand_idx(32), rand_idx(32), 3'(i < 2 ? i : i + 2), r[11:7],
				`OPC_BRANCH});
			idle();
		end

		// stores, loads and the load-use stall
		for (i = 0; i < 6; i++)
		begin
			r = next_rand();
			issue({r[31:25], rand_idx(32), rand_idx(32), 1'b0, 2'(i % 3), r[11:7],
				`OPC_STORE});
			idle();
			issue(enc_i(r[31:20], rand_idx(32), 3'(i < 3 ? i : i + 1), rand_idx(31) + 5'd1,
				`OPC_LOAD));
			idle();
		end
		ld_rd = rand_idx(31) + 5'd1;
		issue(enc_i(12'h010, 5'd0, 3'b010, ld_rd, `OPC_LOAD));
		present(enc_r(`F7_BASE, 5'd0, ld_rd, 3'b000, 5'd7));
		for (i = 0; i < 3; i++)
		begin
			@(negedge cpu_clk);
			compare_value("dec_ready", dec_ready, 1'b0);
			@(posedge cpu_clk);
			model_step(r[0]);
		end
		data_mem <= next_rand();
		rd_mem <= {1'b0, ld_rd};
		mem_wb_data_valid <= 1'b1;
		wait_accept();
		rd_mem <= `NO_REG;
		mem_wb_data_valid <= 1'b0;
		idle();

		// fence window, the fence stays presented throughout
		issue(32'h0ff0000f);
		n = 0;
		for (i = 0; i < 20; i++)
		begin
			@(negedge cpu_clk);
			if (dec_ready)
				break;
			compare_value("fence_dec", fence_dec, 1'b0);
			n++;
			@(posedge cpu_clk);
			model_step(r[0]);
		end
		if (i == 20)
			stop_run("timeout while waiting for dec_ready after the fence");
		compare_value("fence stall cycles", n, `FENCE_STALL_CYCLES);
		compare_value("fence_dec", fence_dec, 1'b1);   // same fence taken again
		@(posedge cpu_clk);
		model_step(r[0]);

		// back-pressure hold, then flush by a taken branch
		issue(rand_alu(5'd9, 5'd3, 5'd4));
		ex_ready <= 1'b0;
		present(rand_alu(5'd10, 5'd5, 5'd6));
		for (i = 0; i < 3; i++)
		begin
			@(negedge cpu_clk);
			check_outputs(last_exp);
			@(posedge cpu_clk);
		end
		branch_taken_ex <= 1'b1;
		ex_ready <= 1'b1;
		@(posedge cpu_clk);
		branch_taken_ex <= 1'b0;
		if_valid <= 1'b0;
		@(negedge cpu_clk);
		compare_value("dec_valid", dec_valid, 1'b0);
		compare_value("alu_op_ex", alu_op_ex, '0);
		compare_value("br_op_ex", br_op_ex, '0);
		compare_value("load_ex", load_ex, 1'b0);
		compare_value("store_ex", store_ex, 1'b0);
		compare_value("jalr_ex", jalr_ex, 1'b0);
		compare_value("only_src2_used_ex", only_src2_used_ex, 1'b0);
		compare_value("rd_ex", rd_ex, `NO_REG);

		n = 0;
		while (exp_q.size() != 0 && n < 10)
		begin
			@(posedge cpu_clk);
			n++;
		end
		if (exp_q.size() != 0)
			stop_run("timeout while waiting for pending output checks");
		else
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule
